/* design/mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// source operand width
`define MUL_XLEN 64

// full product, both halves
`define MUL_PWIDTH (2 * `MUL_XLEN)

// one row per radix-4 digit, plus a row for the top digit
// of an unsigned multiplier
`define MUL_NPP (`MUL_XLEN / 2 + 1)

// request tag carried to the response
`define MUL_TAG_W 4

`endif

/* design/mul_pkg.sv */
`include "mul_defines.svh"

package mul_pkg;

  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    MULW   = 3'd4
  } mul_op_e;

  typedef struct packed {
    logic                  valid;
    mul_op_e               op;
    logic [`MUL_TAG_W-1:0] tag;
    logic [`MUL_XLEN-1:0]  rs1;
    logic [`MUL_XLEN-1:0]  rs2;
  } mul_req_t;

  typedef struct packed {
    logic [`MUL_XLEN-1:0] hi;
    logic [`MUL_XLEN-1:0] lo;
  } mul_halves_t;

  // tree writes the word, result select reads the halves
  typedef union packed {
    logic [`MUL_PWIDTH-1:0] word;
    mul_halves_t            half;
  } mul_product_u;

  typedef struct packed {
    logic                  valid;
    logic [`MUL_TAG_W-1:0] tag;
    logic [`MUL_XLEN-1:0]  result;
  } mul_rsp_t;

  // one partial-product row
  typedef logic [`MUL_PWIDTH-1:0] mul_pp_t;

endpackage

/* design/mul_booth_r4.sv */
`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_booth_r4 (
  input  logic                 rs1_signed_i,
  input  logic                 rs2_signed_i,
  input  logic [`MUL_XLEN-1:0] rs1_data_i,
  input  logic [`MUL_XLEN-1:0] rs2_data_i,
  output mul_pkg::mul_pp_t     pp_o [`MUL_NPP]
);
  import mul_pkg::*;

  localparam int unsigned XLEN = `MUL_XLEN;
  localparam int unsigned PW   = `MUL_PWIDTH;
  localparam int unsigned NPP  = `MUL_NPP;

  logic              rs1_sign;
  logic              rs2_sign;
  // multiplicand times one and times two, both 66 bits signed
  logic [XLEN+1:0]   a_x1;
  logic [XLEN+1:0]   a_x2;
  // multiplier with two extension bits on top and b[-1] at bit 0
  logic [XLEN+2:0]   b_ext;
  logic [NPP-1:0]    neg;

  assign rs1_sign = rs1_signed_i & rs1_data_i[XLEN-1];
  assign rs2_sign = rs2_signed_i & rs2_data_i[XLEN-1];

  assign a_x1  = {rs1_sign, rs1_sign, rs1_data_i};
  assign a_x2  = {rs1_sign, rs1_data_i, 1'b0};
  assign b_ext = {rs2_sign, rs2_sign, rs2_data_i, 1'b0};

  for (genvar i = 0; i < NPP; i++) begin : g_row
    logic [2:0]      trip;
    logic            one;
    logic            two;
    logic [XLEN+1:0] mag;
    logic [XLEN+1:0] term;
    mul_pp_t         row;

    assign trip = b_ext[2*i+2:2*i];

    // digit decode, 111 is treated as +0 so the last row never negates
    assign one    = trip[1] ^ trip[0];
    assign two    = (trip == 3'b011) | (trip == 3'b100);
    assign neg[i] = trip[2] & ~(trip[1] & trip[0]);

    assign mag  = one ? a_x1 : (two ? a_x2 : '0);
    // one's complement here, the +1 lands in the next row
    assign term = neg[i] ? ~mag : mag;
    assign row  = {{(PW-XLEN-2){term[XLEN+1]}}, term};

    if (i == 0) begin : g_first
      assign pp_o[i] = row;
    end else begin : g_rest
      // low bits of a shifted row are free for the previous row's correction
      assign pp_o[i] = (row << (2 * i)) |
                       ({{(PW-1){1'b0}}, neg[i-1]} << (2 * i - 2));
    end
  end

endmodule

/* design/mul_compressor42.sv */
`timescale 1ns/10ps

module mul_compressor42 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic ci_i,
  output logic sum_o,
  output logic carry_o,
  output logic co_o
);

  logic s1;

  // first full adder, its carry goes to the next column
  assign s1   = x0_i ^ x1_i ^ x2_i;
  assign co_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  // second full adder takes the carry from the column below
  assign sum_o   = s1 ^ x3_i ^ ci_i;
  assign carry_o = (s1 & x3_i) | (s1 & ci_i) | (x3_i & ci_i);

endmodule

/* design/mul_compressor52.sv */
`timescale 1ns/10ps

module mul_compressor52 (
  input  logic x0_i,
  input  logic x1_i,
  input  logic x2_i,
  input  logic x3_i,
  input  logic x4_i,
  input  logic ci0_i,
  input  logic ci1_i,
  output logic sum_o,
  output logic carry_o,
  output logic co0_o,
  output logic co1_o
);

  logic s1;
  logic s2;

  // two adders on the vertical inputs only
  assign s1    = x0_i ^ x1_i ^ x2_i;
  assign co0_o = (x0_i & x1_i) | (x0_i & x2_i) | (x1_i & x2_i);

  assign s2    = s1 ^ x3_i ^ x4_i;
  assign co1_o = (s1 & x3_i) | (s1 & x4_i) | (x3_i & x4_i);

  // horizontal carries join in the last adder
  assign sum_o   = s2 ^ ci0_i ^ ci1_i;
  assign carry_o = (s2 & ci0_i) | (s2 & ci1_i) | (ci0_i & ci1_i);

endmodule

/* design/mul_wallace_tree.sv */
`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_wallace_tree #(
  parameter int unsigned SIDE_W = 7
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic [SIDE_W-1:0]     side_i,
  input  mul_pkg::mul_pp_t      pp_i [`MUL_NPP],
  output logic                  valid_o,
  output logic [SIDE_W-1:0]     side_o,
  output mul_pkg::mul_product_u product_o
);
  import mul_pkg::*;

  localparam int unsigned PW = `MUL_PWIDTH;

  // sums in the low half of each array, shifted carries in the high half
  mul_pp_t           l2_in [16];
  mul_pp_t           l3_d  [8];
  mul_pp_t           l3_q  [8];
  mul_pp_t           l4_in [4];
  mul_pp_t           fin   [2];
  logic [PW-1:0]     fin_sum;
  logic              valid_q;
  logic [SIDE_W-1:0] side_q;

  // level 1, rows 0..4 through the 5:2 row
  logic [PW:0]   c52_co0;
  logic [PW:0]   c52_co1;
  logic [PW-1:0] c52_sum;
  logic [PW-1:0] c52_carry;

  assign c52_co0[0] = 1'b0;
  assign c52_co1[0] = 1'b0;

  for (genvar b = 0; b < PW; b++) begin : g_l1_c52
    mul_compressor52 u_c52 (
      .x0_i    (pp_i[0][b]),
      .x1_i    (pp_i[1][b]),
      .x2_i    (pp_i[2][b]),
      .x3_i    (pp_i[3][b]),
      .x4_i    (pp_i[4][b]),
      .ci0_i   (c52_co0[b]),
      .ci1_i   (c52_co1[b]),
      .sum_o   (c52_sum[b]),
      .carry_o (c52_carry[b]),
      .co0_o   (c52_co0[b+1]),
      .co1_o   (c52_co1[b+1])
    );
  end

  assign l2_in[0] = c52_sum;
  assign l2_in[8] = {c52_carry[PW-2:0], 1'b0};

  // level 1, rows 5..32 in groups of four
  for (genvar g = 0; g < 7; g++) begin : g_l1
    logic [PW:0]   co;
    logic [PW-1:0] s;
    logic [PW-1:0] c;

    assign co[0] = 1'b0;
    for (genvar b = 0; b < PW; b++) begin : g_bit
      mul_compressor42 u_c42 (
        .x0_i    (pp_i[5+4*g][b]),
        .x1_i    (pp_i[6+4*g][b]),
        .x2_i    (pp_i[7+4*g][b]),
        .x3_i    (pp_i[8+4*g][b]),
        .ci_i    (co[b]),
        .sum_o   (s[b]),
        .carry_o (c[b]),
        .co_o    (co[b+1])
      );
    end
    assign l2_in[g+1] = s;
    assign l2_in[g+9] = {c[PW-2:0], 1'b0};
  end

  // level 2, 16 rows to 8
  for (genvar g = 0; g < 4; g++) begin : g_l2
    logic [PW:0]   co;
    logic [PW-1:0] s;
    logic [PW-1:0] c;

    assign co[0] = 1'b0;
    for (genvar b = 0; b < PW; b++) begin : g_bit
      mul_compressor42 u_c42 (
        .x0_i    (l2_in[4*g][b]),
        .x1_i    (l2_in[4*g+1][b]),
        .x2_i    (l2_in[4*g+2][b]),
        .x3_i    (l2_in[4*g+3][b]),
        .ci_i    (co[b]),
        .sum_o   (s[b]),
        .carry_o (c[b]),
        .co_o    (co[b+1])
      );
    end
    assign l3_d[g]   = s;
    assign l3_d[g+4] = {c[PW-2:0], 1'b0};
  end

  // mid-tree pipeline register
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    side_q <= side_i;
    l3_q   <= l3_d;
  end

  // level 3, 8 rows to 4
  for (genvar g = 0; g < 2; g++) begin : g_l3
    logic [PW:0]   co;
    logic [PW-1:0] s;
    logic [PW-1:0] c;

    assign co[0] = 1'b0;
    for (genvar b = 0; b < PW; b++) begin : g_bit
      mul_compressor42 u_c42 (
        .x0_i    (l3_q[4*g][b]),
        .x1_i    (l3_q[4*g+1][b]),
        .x2_i    (l3_q[4*g+2][b]),
        .x3_i    (l3_q[4*g+3][b]),
        .ci_i    (co[b]),
        .sum_o   (s[b]),
        .carry_o (c[b]),
        .co_o    (co[b+1])
      );
    end
    assign l4_in[g]   = s;
    assign l4_in[g+2] = {c[PW-2:0], 1'b0};
  end

  // level 4, last 4:2 row leaves sum and carry
  logic [PW:0]   l4_co;
  logic [PW-1:0] l4_sum;
  logic [PW-1:0] l4_carry;

  assign l4_co[0] = 1'b0;

  for (genvar b = 0; b < PW; b++) begin : g_l4
    mul_compressor42 u_c42 (
      .x0_i    (l4_in[0][b]),
      .x1_i    (l4_in[1][b]),
      .x2_i    (l4_in[2][b]),
      .x3_i    (l4_in[3][b]),
      .ci_i    (l4_co[b]),
      .sum_o   (l4_sum[b]),
      .carry_o (l4_carry[b]),
      .co_o    (l4_co[b+1])
    );
  end

  assign fin[0] = l4_sum;
  assign fin[1] = {l4_carry[PW-2:0], 1'b0};

  // carry-propagate add, wraps at the product width
  assign fin_sum = fin[0] + fin[1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    side_o         <= side_q;
    product_o.word <= fin_sum;
  end

endmodule

/* design/mul_unit.sv */
`timescale 1ns/10ps
`include "mul_defines.svh"

module mul_unit (
  input  logic              clk,
  input  logic              rst_i,
  input  mul_pkg::mul_req_t req_i,
  output mul_pkg::mul_rsp_t rsp_o
);
  import mul_pkg::*;

  localparam int unsigned XLEN   = `MUL_XLEN;
  localparam int unsigned HALF   = `MUL_XLEN / 2;
  localparam int unsigned OP_W   = $bits(mul_op_e);
  localparam int unsigned SIDE_W = OP_W + `MUL_TAG_W;

  logic                  rs1_signed;
  logic                  rs2_signed;
  logic [XLEN-1:0]       rs1_opnd;
  logic [XLEN-1:0]       rs2_opnd;
  mul_pp_t               pp [`MUL_NPP];
  logic [SIDE_W-1:0]     side_in;
  logic [SIDE_W-1:0]     side_out;
  logic                  valid_out;
  mul_op_e               op_out;
  logic [`MUL_TAG_W-1:0] tag_out;
  mul_product_u          product;

  // operand signedness per operation
  always_comb begin
    rs1_signed = 1'b1;
    rs2_signed = 1'b1;
    rs1_opnd   = req_i.rs1;
    rs2_opnd   = req_i.rs2;
    case (req_i.op)
      MULHSU: begin
        rs2_signed = 1'b0;
      end
      MULHU: begin
        rs1_signed = 1'b0;
        rs2_signed = 1'b0;
      end
      MULW: begin
        // only the low words count
        rs1_opnd = {{HALF{req_i.rs1[HALF-1]}}, req_i.rs1[HALF-1:0]};
        rs2_opnd = {{HALF{req_i.rs2[HALF-1]}}, req_i.rs2[HALF-1:0]};
      end
      default: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b1;
      end
    endcase
  end

  mul_booth_r4 u_mul_booth_r4 (
    .rs1_signed_i (rs1_signed),
    .rs2_signed_i (rs2_signed),
    .rs1_data_i   (rs1_opnd),
    .rs2_data_i   (rs2_opnd),
    .pp_o         (pp)
  );

  // op and tag ride along with the tree stages
  assign side_in = {req_i.op, req_i.tag};

  mul_wallace_tree #(
    .SIDE_W (SIDE_W)
  ) u_mul_wallace_tree (
    .clk       (clk),
    .rst_i     (rst_i),
    .valid_i   (req_i.valid),
    .side_i    (side_in),
    .pp_i      (pp),
    .valid_o   (valid_out),
    .side_o    (side_out),
    .product_o (product)
  );

  assign op_out  = mul_op_e'(side_out[SIDE_W-1 -: OP_W]);
  assign tag_out = side_out[`MUL_TAG_W-1:0];

  // result select
  always_comb begin
    rsp_o.valid = valid_out;
    rsp_o.tag   = tag_out;
    case (op_out)
      MULH, MULHSU, MULHU: begin
        rsp_o.result = product.half.hi;
      end
      MULW: begin
        rsp_o.result = {{HALF{product.half.lo[HALF-1]}}, product.half.lo[HALF-1:0]};
      end
      default: begin
        rsp_o.result = product.half.lo;
      end
    endcase
  end

endmodule

/* sim/tb_mul_unit.sv */
`timescale 1ns/10ps
`include "mul_defines.svh"

module tb_mul_unit;
  import mul_pkg::*;

  localparam int XLEN   = `MUL_XLEN;
  localparam int N_RAND = 200;
  localparam logic [XLEN-1:0] ONES  = 64'hFFFF_FFFF_FFFF_FFFF;
  localparam logic [XLEN-1:0] MAXN  = 64'h8000_0000_0000_0000;
  localparam logic [XLEN-1:0] MAXP  = 64'h7FFF_FFFF_FFFF_FFFF;
  localparam logic [XLEN-1:0] FIVES = 64'h5555_5555_5555_5555;

  typedef struct packed {
    mul_op_e         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] result;
  } vec_t;

  // what the scoreboard waits for
  typedef struct packed {
    logic [`MUL_TAG_W-1:0] tag;
    logic [XLEN-1:0]       result;
    logic [31:0]           due;
  } expect_t;

  logic                  clk;
  logic                  rst;
  mul_req_t              req;
  mul_rsp_t              rsp;
  vec_t                  tbl [$];
  expect_t               exp_q [$];
  int                    cycle;
  int                    limit;
  int                    errors;
  int                    seed_ret;
  int                    idle_budget;
  logic [`MUL_TAG_W-1:0] tag_cnt;

  mul_unit mul_unit_i (
    .clk   (clk),
    .rst_i (rst),
    .req_i (req),
    .rsp_o (rsp)
  );

  always #4 clk = ~clk;

  // golden product with operands extended per op
  function automatic logic [XLEN-1:0] ref_result(input mul_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    ea = (op == MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    eb = (op == MULHU || op == MULHSU) ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
    if (op == MULW) begin
      ea = {{(2*XLEN-32){a[31]}}, a[31:0]};
      eb = {{(2*XLEN-32){b[31]}}, b[31:0]};
    end
    prod = ea * eb;
    case (op)
      MULH, MULHSU, MULHU: return prod[2*XLEN-1:XLEN];
      MULW: return {{(XLEN-32){prod[31]}}, prod[31:0]};
      default: return prod[XLEN-1:0];
    endcase
  endfunction

  function automatic logic [XLEN-1:0] pick_operand();
    int sel;
    sel = $urandom % 8;
    case (sel)
      0: return '0;
      1: return ONES;
      2: return MAXN;
      3: return MAXP;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic add_vec(input mul_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] r);
    vec_t v;
    v.op     = op;
    v.rs1    = a;
    v.rs2    = b;
    v.result = r;
    tbl.push_back(v);
  endtask

  task automatic build_table();
    add_vec(MUL,    64'h0,  64'h0, 64'h0);
    add_vec(MUL,    64'h1,  ONES,  ONES);
    add_vec(MUL,    ONES,   ONES,  64'h1);
    // most negative times -1 wraps to itself
    add_vec(MUL,    MAXN,   ONES,  MAXN);
    add_vec(MUL,    MAXP,   MAXP,  64'h1);
    add_vec(MUL,    MAXP,   MAXN,  MAXN);
    add_vec(MUL,    FIVES,  64'h3, ONES);
    add_vec(MUL,    FIVES,  ONES,  64'hAAAA_AAAA_AAAA_AAAB);
    add_vec(MULH,   MAXN,   ONES,  64'h0);
    add_vec(MULH,   ONES,   ONES,  64'h0);
    add_vec(MULH,   MAXP,   MAXP,  64'h3FFF_FFFF_FFFF_FFFF);
    add_vec(MULH,   MAXN,   MAXN,  64'h4000_0000_0000_0000);
    add_vec(MULH,   MAXP,   MAXN,  64'hC000_0000_0000_0000);
    add_vec(MULH,   FIVES,  ONES,  ONES);
    add_vec(MULH,   ONES,   64'h2, ONES);
    add_vec(MULHSU, ONES,   ONES,  ONES);
    add_vec(MULHSU, MAXN,   ONES,  MAXN);
    add_vec(MULHSU, 64'h2,  ONES,  64'h1);
    add_vec(MULHSU, ONES,   64'h2, ONES);
    add_vec(MULHSU, 64'h0,  ONES,  64'h0);
    add_vec(MULHU,  ONES,   ONES,  64'hFFFF_FFFF_FFFF_FFFE);
    add_vec(MULHU,  MAXN,   MAXN,  64'h4000_0000_0000_0000);
    add_vec(MULHU,  ONES,   64'h2, 64'h1);
    add_vec(MULHU,  FIVES,  64'h3, 64'h0);
    // upper words must be ignored
    add_vec(MULW,   64'hDEAD_BEEF_0000_0002, 64'h1234_5678_0000_0003, 64'h6);
    add_vec(MULW,   64'hFFFF_FFFF, 64'hFFFF_FFFF, 64'h1);
    add_vec(MULW,   64'h8000_0000, 64'hFFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
    add_vec(MULW,   64'h7FFF_FFFF, 64'h2,         64'hFFFF_FFFF_FFFF_FFFE);
    add_vec(MULW,   64'h0001_0000, 64'h0001_0000, 64'h0);
    add_vec(MULW,   64'hFFFF_FFFF_0000_0005, 64'h7, 64'h23);
  endtask

  task automatic issue(input mul_op_e op, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b, input logic [XLEN-1:0] r);
    expect_t e;
    @(posedge clk);
    #1;
    req.valid = 1'b1;
    req.op    = op;
    req.tag   = tag_cnt;
    req.rs1   = a;
    req.rs2   = b;
    e.tag     = tag_cnt;
    e.result  = r;
    // sampled at the next edge and answered two edges later
    e.due     = cycle + 2;
    exp_q.push_back(e);
    tag_cnt   = tag_cnt + 1'b1;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    req.valid = 1'b0;
  endtask

  // cycle count and timeout
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (limit > 0 && cycle > limit) begin
      $display("timeout: run stopped at cycle %0d with %0d responses outstanding",
               cycle, exp_q.size());
      $display("errors: %0d", errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // scoreboard samples mid-cycle
  always @(negedge clk) begin : scoreboard
    expect_t e;
    if (!rst) begin
      if (rsp.valid) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response at %0t with tag %0h", $time, rsp.tag);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (cycle != e.due) begin
            $display("response with tag %0h came at cycle %0d instead of cycle %0d",
                     rsp.tag, cycle, e.due);
            errors++;
          end
          if (rsp.tag !== e.tag) begin
            $display("[ERROR] %0t rsp_o.tag expected %h actual %h", $time, e.tag, rsp.tag);
            errors++;
          end
          if (rsp.result !== e.result) begin
            $display("[ERROR] %0t rsp_o.result expected %h actual %h",
                     $time, e.result, rsp.result);
            errors++;
          end
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
        e = exp_q.pop_front();
        $display("missing response for tag %0h due at cycle %0d", e.tag, e.due);
        errors++;
      end
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    req         = '0;
    cycle       = 0;
    limit       = 0;
    errors      = 0;
    tag_cnt     = '0;
    idle_budget = 24;
    seed_ret    = $urandom(79);
    build_table();
    limit = tbl.size() + N_RAND + 50;

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // nothing issued yet so valid must stay low
    repeat (3) idle();

    foreach (tbl[i]) begin
      if (ref_result(tbl[i].op, tbl[i].rs1, tbl[i].rs2) !== tbl[i].result) begin
        $display("table entry %0d disagrees with the reference model", i);
        errors++;
      end
      issue(tbl[i].op, tbl[i].rs1, tbl[i].rs2, tbl[i].result);
    end

    for (int n = 0; n < N_RAND; n++) begin
      mul_op_e op;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      if (idle_budget > 0 && ($urandom % 6) == 0) begin
        idle();
        idle_budget--;
      end
      op = mul_op_e'($urandom % 5);
      a  = pick_operand();
      b  = pick_operand();
      issue(op, a, b, ref_result(op, a, b));
    end
    idle();

    while (exp_q.size() != 0) @(posedge clk);
    // a few more cycles to catch stray responses
    repeat (4) @(posedge clk);
    @(negedge clk);
    // let the last scoreboard pass settle
    #1;

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/mul_pkg.sv
design/mul_booth_r4.sv
design/mul_compressor42.sv
design/mul_compressor52.sv
design/mul_wallace_tree.sv
design/mul_unit.sv
sim/tb_mul_unit.sv

/* Bender.yml */
package:
  name: mul_unit

sources:
  - include_dirs:
      - design
    files:
      - design/mul_pkg.sv
      - design/mul_booth_r4.sv
      - design/mul_compressor42.sv
      - design/mul_compressor52.sv
      - design/mul_wallace_tree.sv
      - design/mul_unit.sv

  - target: test
    include_dirs:
      - design
    files:
      - sim/tb_mul_unit.sv
